//--- all.f
video_pkg.sv
video_ports.sv
video_sync.sv
video_fetch.sv
video_render.sv
video_top.sv
video_top_properties.sv
tb_video_checker.sv
tb_video_top.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = tb_video_top
FILELIST = all.f
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tb_video_top.sv
module tb_video_top;

	localparam int H_ACTIVE = 32;
	localparam int H_TOTAL = 48;
	localparam int V_ACTIVE = 8;
	localparam int V_TOTAL = 12;
	localparam int NUM_TESTS = 4;
	localparam int CYCLE_LIMIT = (NUM_TESTS + 2) * H_TOTAL * V_TOTAL * 2;

	// {border[23:20], gfx[16], page[15:8], palette seed[5:0]}
	localparam logic [23:0] TESTS [0:NUM_TESTS-1] = '{
		24'h500011,
		24'h311207,
		24'ha1072c,
		24'hf1ff3a
	};

	logic clk;
	logic rst;
	logic [7:0] d;
	logic border_wr;
	logic vconf_wr;
	logic vpage_wr;
	logic cram_we;
	logic [3:0] zma;
	logic [5:0] zmd;
	video_pkg::dram_addr_t video_addr;
	logic video_go;
	logic video_next;
	video_pkg::dram_word_t dram_rdata;
	logic [1:0] vred;
	logic [1:0] vgrn;
	logic [1:0] vblu;
	logic hsync;
	logic vsync;
	logic int_start;

	logic arm;
	logic [3:0] exp_border;
	logic exp_gfx;
	logic [7:0] exp_page;
	logic [5:0] exp_seed;
	int tests_done;
	int tests_pass;
	int tests_fail;
	int errors;

	logic [31:0] lfsr;
	int stall;
	logic have_wait;
	int cycles;

	video_top #(
		.H_ACTIVE (H_ACTIVE),
		.H_TOTAL  (H_TOTAL),
		.V_ACTIVE (V_ACTIVE),
		.V_TOTAL  (V_TOTAL)
	) DUT (
		.clk        (clk),
		.rst        (rst),
		.d          (d),
		.border_wr  (border_wr),
		.vconf_wr   (vconf_wr),
		.vpage_wr   (vpage_wr),
		.cram_we    (cram_we),
		.zma        (zma),
		.zmd        (zmd),
		.video_addr (video_addr),
		.video_go   (video_go),
		.video_next (video_next),
		.dram_rdata (dram_rdata),
		.vred       (vred),
		.vgrn       (vgrn),
		.vblu       (vblu),
		.hsync      (hsync),
		.vsync      (vsync),
		.int_start  (int_start)
	);

	tb_video_checker #(
		.H_ACTIVE (H_ACTIVE),
		.H_TOTAL  (H_TOTAL),
		.V_ACTIVE (V_ACTIVE),
		.V_TOTAL  (V_TOTAL)
	) pixel_check (
		.clk        (clk),
		.rst        (rst),
		.vred       (vred),
		.vgrn       (vgrn),
		.vblu       (vblu),
		.hsync      (hsync),
		.vsync      (vsync),
		.int_start  (int_start),
		.video_addr (video_addr),
		.video_go   (video_go),
		.video_next (video_next),
		.arm        (arm),
		.exp_border (exp_border),
		.exp_gfx    (exp_gfx),
		.exp_page   (exp_page),
		.exp_seed   (exp_seed),
		.tests_done (tests_done),
		.tests_pass (tests_pass),
		.tests_fail (tests_fail),
		.errors     (errors)
	);

	always #10 clk = ~clk;

	// galois lfsr, x^32 + x^22 + x^2 + x + 1
	function automatic logic next_random_bit();
		lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h80200003 : 32'h0);
		return lfsr[0];
	endfunction

	// dram model, ready after 1 to 3 idle cycles per word
	always @(negedge clk) begin
		logic [1:0] r;
		if (rst) begin
			video_next = 1'b0;
			have_wait = 1'b0;
			stall = 0;
		end else begin
			video_next = 1'b0;
			if (video_go) begin
				if (!have_wait) begin
					r[1] = next_random_bit();
					r[0] = next_random_bit();
					stall = 1 + int'(r) % 3;
					have_wait = 1'b1;
				end
				if (stall == 0) begin
					video_next = 1'b1;
					dram_rdata = video_addr[15:0] ^ 16'h5a3c;
					have_wait = 1'b0;
				end else begin
					stall = stall - 1;
				end
			end else begin
				have_wait = 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic wait_frame_start();
		@(negedge clk);
		while (!int_start)
			@(negedge clk);
	endtask

	// sel 0 border, 1 vconf, 2 vpage
	task automatic port_write(input int sel, input logic [7:0] val);
		d = val;
		border_wr = (sel == 0);
		vconf_wr = (sel == 1);
		vpage_wr = (sel == 2);
		@(negedge clk);
		border_wr = 1'b0;
		vconf_wr = 1'b0;
		vpage_wr = 1'b0;
	endtask

	task automatic palette_write(input logic [3:0] idx, input logic [5:0] col);
		zma = idx;
		zmd = col;
		cram_we = 1'b1;
		@(negedge clk);
		cram_we = 1'b0;
	endtask

	initial begin
		logic [23:0] row;
		clk = 1'b0;
		rst = 1'b1;
		d = '0;
		border_wr = 1'b0;
		vconf_wr = 1'b0;
		vpage_wr = 1'b0;
		cram_we = 1'b0;
		zma = '0;
		zmd = '0;
		video_next = 1'b0;
		dram_rdata = '0;
		arm = 1'b0;
		exp_border = '0;
		exp_gfx = 1'b0;
		exp_page = '0;
		exp_seed = '0;
		lfsr = 32'h2b317448;
		cycles = 0;
		repeat (2) @(negedge clk);
		rst = 1'b0;

		for (int t = 0; t < NUM_TESTS; t++) begin
			row = TESTS[t];
			// setup frame, nothing checked here
			wait_frame_start();
			for (int i = 0; i < 16; i++)
				palette_write(4'(i), row[5:0] + 6'(i));
			port_write(0, {4'h0, row[23:20]});
			port_write(1, {7'h0, row[16]});
			port_write(2, row[15:8]);
			exp_border = row[23:20];
			exp_gfx = row[16];
			exp_page = row[15:8];
			exp_seed = row[5:0];
			arm = 1'b1;
			wait_frame_start();
			@(negedge clk);
			arm = 1'b0;
			// mid-frame writes must wait for the next frame
			repeat (3 * H_TOTAL) @(negedge clk);
			port_write(0, {4'h0, ~row[23:20]});
			port_write(1, {7'h0, ~row[16]});
			port_write(2, row[15:8] ^ 8'h55);
		end

		while (tests_done < NUM_TESTS)
			@(negedge clk);
		$display("tests passed %0d, failed %0d, mismatches %0d", tests_pass, tests_fail, errors);
		if (tests_fail == 0 && errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- tb_video_checker.sv
module tb_video_checker #(
	parameter int H_ACTIVE = 32,
	parameter int H_TOTAL = 48,
	parameter int V_ACTIVE = 8,
	parameter int V_TOTAL = 12
) (
	input logic clk,
	input logic rst,
	input logic [1:0] vred,
	input logic [1:0] vgrn,
	input logic [1:0] vblu,
	input logic hsync,
	input logic vsync,
	input logic int_start,
	input video_pkg::dram_addr_t video_addr,
	input logic video_go,
	input logic video_next,
	input logic arm,
	input logic [3:0] exp_border,
	input logic exp_gfx,
	input logic [7:0] exp_page,
	input logic [5:0] exp_seed,
	output int tests_done,
	output int tests_pass,
	output int tests_fail,
	output int errors
);

	int hx;
	int vy;
	logic checking;
	int frame_err;

	// palette entry i holds seed + i, pixel data is address xor 5a3c
	function automatic logic [5:0] expected_color(input int x, input int y);
		logic [15:0] word;
		logic [3:0] idx;
		idx = exp_border;
		if (exp_gfx && x < H_ACTIVE && y < V_ACTIVE) begin
			word = {exp_page[2:0], 7'(y), 6'(x / 4)} ^ 16'h5a3c;
			idx = word[4 * (3 - x % 4) +: 4];
		end
		return exp_seed + 6'(idx);
	endfunction

	task automatic compare_signal(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s at (%0d,%0d): got %h expected %h", name, hx, vy, got, exp);
			frame_err++;
			errors++;
		end
	endtask

	task automatic check_position();
		logic [5:0] col;
		logic hs_exp;
		logic vs_exp;
		col = expected_color(hx, vy);
		hs_exp = (hx >= H_ACTIVE + video_pkg::H_SYNC_START_OFS) &&
			(hx < H_ACTIVE + video_pkg::H_SYNC_START_OFS + video_pkg::H_SYNC_LEN);
		vs_exp = (vy >= V_ACTIVE + video_pkg::V_SYNC_START_OFS) &&
			(vy < V_ACTIVE + video_pkg::V_SYNC_START_OFS + video_pkg::V_SYNC_LEN);
		compare_signal("vred", {6'h0, vred}, {6'h0, col[5:4]});
		compare_signal("vgrn", {6'h0, vgrn}, {6'h0, col[3:2]});
		compare_signal("vblu", {6'h0, vblu}, {6'h0, col[1:0]});
		compare_signal("hsync", {7'h0, hsync}, {7'h0, hs_exp});
		compare_signal("vsync", {7'h0, vsync}, {7'h0, vs_exp});
		// reads during line y fetch row y + 1 from this frame's page
		if (video_go && video_next && vy < V_ACTIVE - 1) begin
			compare_signal("video_addr page", video_addr[20:13], exp_page);
			compare_signal("video_addr row", {1'b0, video_addr[12:6]}, 8'(vy + 1));
		end
	endtask

	// int_start marks output position (0,0)
	always @(posedge clk) begin
		if (rst) begin
			checking = 1'b0;
			hx = 0;
			vy = 0;
			frame_err = 0;
			tests_done = 0;
			tests_pass = 0;
			tests_fail = 0;
			errors = 0;
		end else if (int_start) begin
			if (checking) begin
				if (hx != H_TOTAL - 1 || vy != V_TOTAL - 1) begin
					$display("int_start came at (%0d,%0d) instead of a frame end", hx, vy);
					frame_err++;
					errors++;
				end
				$display("test %0d: %s, %0d mismatches", tests_done,
					(frame_err == 0) ? "pass" : "fail", frame_err);
				if (frame_err == 0)
					tests_pass++;
				else
					tests_fail++;
				tests_done++;
			end
			hx = 0;
			vy = 0;
			frame_err = 0;
			checking = arm;
			if (checking)
				check_position();
		end else begin
			hx++;
			if (hx == H_TOTAL) begin
				hx = 0;
				vy = (vy == V_TOTAL - 1) ? 0 : vy + 1;
			end
			if (checking)
				check_position();
		end
	end

endmodule

//--- video_top_properties.sv
module video_top_properties (
	input logic clk,
	input logic rst,
	input logic video_go,
	input logic video_next,
	input video_pkg::dram_addr_t video_addr,
	input logic line_start,
	input logic active,
	input logic hsync,
	input logic int_start
);

	// request holds until ready, unless a new line drops it
	a_go_hold: assert property (@(posedge clk) disable iff (rst)
		video_go && !video_next && !line_start |=> video_go && $stable(video_addr))
		else $error("video_go or video_addr changed before video_next");

	a_int_pulse: assert property (@(posedge clk) disable iff (rst)
		int_start |=> !int_start)
		else $error("int_start longer than one cycle");

	// active delayed by the two pipeline stages
	a_hsync_blank: assert property (@(posedge clk) disable iff (rst)
		!(hsync && $past(active, 2)))
		else $error("hsync inside the active window");

	a_go_reset: assert property (@(posedge clk) rst |=> !video_go)
		else $error("video_go high after reset");

endmodule

bind video_top video_top_properties props (
	.clk        (clk),
	.rst        (rst),
	.video_go   (video_go),
	.video_next (video_next),
	.video_addr (video_addr),
	.line_start (line_start),
	.active     (active),
	.hsync      (hsync),
	.int_start  (int_start)
);

//--- video_top.sv
module video_top #(
	parameter int H_ACTIVE = 256,
	parameter int H_TOTAL = 320,
	parameter int V_ACTIVE = 120,
	parameter int V_TOTAL = 144
) (
	input logic clk,
	input logic rst,
	// cpu port writes
	input logic [7:0] d,
	input logic border_wr,
	input logic vconf_wr,
	input logic vpage_wr,
	input logic cram_we,
	input logic [3:0] zma,
	input logic [5:0] zmd,
	// dram read port
	output video_pkg::dram_addr_t video_addr,
	output logic video_go,
	input logic video_next,
	input video_pkg::dram_word_t dram_rdata,
	// video out
	output logic [1:0] vred,
	output logic [1:0] vgrn,
	output logic [1:0] vblu,
	output logic hsync,
	output logic vsync,
	output logic int_start
);

	logic line_start;
	logic frame_start;
	logic active;
	logic [6:0] row;
	logic buf_sel;
	logic [5:0] pix_x;
	video_pkg::color_idx_t border;
	logic gfx_en;
	video_pkg::page_t vpage;
	video_pkg::color_idx_t pal_idx;
	video_pkg::color_t pal_color;
	logic buf_wr_en;
	logic [5:0] buf_wr_word;
	video_pkg::dram_word_t buf_wr_data;

	video_ports video_ports (
		.clk         (clk),
		.rst         (rst),
		.d           (d),
		.border_wr   (border_wr),
		.vconf_wr    (vconf_wr),
		.vpage_wr    (vpage_wr),
		.cram_we     (cram_we),
		.zma         (zma),
		.zmd         (zmd),
		.frame_start (frame_start),
		.border      (border),
		.gfx_en      (gfx_en),
		.vpage       (vpage),
		.pal_idx     (pal_idx),
		.pal_color   (pal_color)
	);

	video_sync #(
		.H_ACTIVE (H_ACTIVE),
		.H_TOTAL  (H_TOTAL),
		.V_ACTIVE (V_ACTIVE),
		.V_TOTAL  (V_TOTAL)
	) video_sync (
		.clk         (clk),
		.rst         (rst),
		.line_start  (line_start),
		.frame_start (frame_start),
		.active      (active),
		.row         (row),
		.buf_sel     (buf_sel),
		.pix_x       (pix_x),
		.hsync       (hsync),
		.vsync       (vsync),
		.int_start   (int_start)
	);

	video_fetch #(
		.H_ACTIVE (H_ACTIVE),
		.V_ACTIVE (V_ACTIVE),
		.V_TOTAL  (V_TOTAL)
	) video_fetch (
		.clk         (clk),
		.rst         (rst),
		.line_start  (line_start),
		.row         (row),
		.vpage       (vpage),
		.video_addr  (video_addr),
		.video_go    (video_go),
		.video_next  (video_next),
		.dram_rdata  (dram_rdata),
		.buf_wr_en   (buf_wr_en),
		.buf_wr_word (buf_wr_word),
		.buf_wr_data (buf_wr_data)
	);

	video_render #(
		.H_ACTIVE (H_ACTIVE)
	) video_render (
		.clk         (clk),
		.rst         (rst),
		.buf_sel     (buf_sel),
		.buf_wr_en   (buf_wr_en),
		.buf_wr_word (buf_wr_word),
		.buf_wr_data (buf_wr_data),
		.active      (active),
		.pix_x       (pix_x),
		.gfx_en      (gfx_en),
		.border      (border),
		.pal_idx     (pal_idx),
		.pal_color   (pal_color),
		.vred        (vred),
		.vgrn        (vgrn),
		.vblu        (vblu)
	);

endmodule

//--- video_render.sv
module video_render #(
	parameter int H_ACTIVE = 256
) (
	input logic clk,
	input logic rst,
	input logic buf_sel,
	input logic buf_wr_en,
	input logic [5:0] buf_wr_word,
	input video_pkg::dram_word_t buf_wr_data,
	input logic active,
	input logic [5:0] pix_x,
	input logic gfx_en,
	input video_pkg::color_idx_t border,
	output video_pkg::color_idx_t pal_idx,
	input video_pkg::color_t pal_color,
	output logic [1:0] vred,
	output logic [1:0] vgrn,
	output logic [1:0] vblu
);

	localparam int WORDS = H_ACTIVE / 4;

	// two halves of 64 words, half select in the top address bit
	video_pkg::dram_word_t line_buf [0:127];
	video_pkg::dram_word_t rd_word;
	logic [1:0] phase;
	video_pkg::color_idx_t nibble;
	logic show_gfx;

	// fetcher fills the half not on screen
	always_ff @(posedge clk) begin
		if (buf_wr_en)
			line_buf[{~buf_sel, buf_wr_word}] <= buf_wr_data;
	end

	assign rd_word = line_buf[{buf_sel, pix_x}];

	// pixel within the word, restarts with each active line
	always_ff @(posedge clk) begin
		if (rst || !active)
			phase <= '0;
		else
			phase <= phase + 2'd1;
	end

	// phase 0 takes the high nibble
	assign nibble = rd_word[{~phase, 2'b00} +: 4];

	// only words that the fetcher filled
	assign show_gfx = active && gfx_en && ({1'b0, pix_x} < 7'(WORDS));
	assign pal_idx = show_gfx ? nibble : border;

	// palette result arrives one cycle later, register it out
	always_ff @(posedge clk) begin
		if (rst) begin
			vred <= '0;
			vgrn <= '0;
			vblu <= '0;
		end else begin
			vred <= pal_color[5:4];
			vgrn <= pal_color[3:2];
			vblu <= pal_color[1:0];
		end
	end

endmodule

//--- video_fetch.sv
module video_fetch #(
	parameter int H_ACTIVE = 256,
	parameter int V_ACTIVE = 120,
	parameter int V_TOTAL = 144
) (
	input logic clk,
	input logic rst,
	input logic line_start,
	input logic [6:0] row,
	input video_pkg::page_t vpage,
	output video_pkg::dram_addr_t video_addr,
	output logic video_go,
	input logic video_next,
	input video_pkg::dram_word_t dram_rdata,
	output logic buf_wr_en,
	output logic [5:0] buf_wr_word,
	output video_pkg::dram_word_t buf_wr_data
);

	localparam int WORDS = H_ACTIVE / 4;

	video_pkg::fetch_state_t state;
	logic [5:0] word;
	logic [6:0] fetch_row;
	video_pkg::page_t page_q;
	logic [6:0] next_row;
	logic need_fetch;
	logic last_word;

	// the row shown on the following line
	assign next_row = (row == 7'(V_TOTAL - 1)) ? 7'd0 : row + 7'd1;
	assign need_fetch = ({1'b0, next_row} < 8'(V_ACTIVE));
	assign last_word = (word == 6'(WORDS - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= video_pkg::IDLE;
			word <= '0;
			fetch_row <= '0;
			page_q <= '0;
		end else if (line_start) begin
			// a fetch still running here is dropped
			word <= '0;
			if (need_fetch) begin
				state <= video_pkg::REQUEST;
				fetch_row <= next_row;
				// row 0 goes out during the last line, so the whole
				// next frame is read from one page
				if (next_row == 7'd0)
					page_q <= vpage;
			end else begin
				state <= video_pkg::IDLE;
			end
		end else begin
			case (state)
				video_pkg::REQUEST: begin
					if (video_next) begin
						if (last_word)
							state <= video_pkg::DONE;
						else
							word <= word + 6'd1;
					end
				end
				// idle and done wait for the next line
				default: begin
					state <= state;
				end
			endcase
		end
	end

	// request held with a stable address until ready
	assign video_go = (state == video_pkg::REQUEST);
	assign video_addr = {page_q, fetch_row, word};

	// data is valid in the ready cycle and goes straight to the buffer
	assign buf_wr_en = video_go && video_next && !line_start;
	assign buf_wr_word = word;
	assign buf_wr_data = dram_rdata;

endmodule

//--- video_sync.sv
module video_sync #(
	parameter int H_ACTIVE = 256,
	parameter int H_TOTAL = 320,
	parameter int V_ACTIVE = 120,
	parameter int V_TOTAL = 144
) (
	input logic clk,
	input logic rst,
	output logic line_start,
	output logic frame_start,
	output logic active,
	output logic [6:0] row,
	output logic buf_sel,
	output logic [5:0] pix_x,
	output logic hsync,
	output logic vsync,
	output logic int_start
);

	localparam int HW = $clog2(H_TOTAL);
	localparam int VW = $clog2(V_TOTAL);

	// sync windows, one bit wider so the end may reach the total
	localparam logic [HW:0] HS_BEG = (HW + 1)'(H_ACTIVE + video_pkg::H_SYNC_START_OFS);
	localparam logic [HW:0] HS_END = (HW + 1)'(H_ACTIVE + video_pkg::H_SYNC_START_OFS +
		video_pkg::H_SYNC_LEN);
	localparam logic [VW:0] VS_BEG = (VW + 1)'(V_ACTIVE + video_pkg::V_SYNC_START_OFS);
	localparam logic [VW:0] VS_END = (VW + 1)'(V_ACTIVE + video_pkg::V_SYNC_START_OFS +
		video_pkg::V_SYNC_LEN);

	logic [HW-1:0] h;
	logic [VW-1:0] v;
	logic last_h;
	logic last_v;
	logic hsync_raw;
	logic vsync_raw;
	logic [1:0] hs_d;
	logic [1:0] vs_d;
	logic [1:0] int_d;

	assign last_h = (h == HW'(H_TOTAL - 1));
	assign last_v = (v == VW'(V_TOTAL - 1));

	// raster counters
	always_ff @(posedge clk) begin
		if (rst) begin
			h <= '0;
			v <= '0;
		end else if (last_h) begin
			h <= '0;
			if (last_v)
				v <= '0;
			else
				v <= v + 1'b1;
		end else begin
			h <= h + 1'b1;
		end
	end

	// events for the current position
	assign line_start = (h == '0);
	assign frame_start = (h == '0) && (v == '0);
	assign active = (h < HW'(H_ACTIVE)) && (v < VW'(V_ACTIVE));

	assign row = 7'(v);
	assign buf_sel = v[0];
	// word index within the line
	assign pix_x = 6'(h >> 2);

	assign hsync_raw = ({1'b0, h} >= HS_BEG) && ({1'b0, h} < HS_END);
	assign vsync_raw = ({1'b0, v} >= VS_BEG) && ({1'b0, v} < VS_END);

	// two stages to line up with palette read and output register
	always_ff @(posedge clk) begin
		if (rst) begin
			hs_d <= '0;
			vs_d <= '0;
			int_d <= '0;
		end else begin
			hs_d <= {hs_d[0], hsync_raw};
			vs_d <= {vs_d[0], vsync_raw};
			int_d <= {int_d[0], frame_start};
		end
	end

	assign hsync = hs_d[1];
	assign vsync = vs_d[1];
	assign int_start = int_d[1];

endmodule

//--- video_ports.sv
module video_ports (
	input logic clk,
	input logic rst,
	input logic [7:0] d,
	input logic border_wr,
	input logic vconf_wr,
	input logic vpage_wr,
	input logic cram_we,
	input logic [3:0] zma,
	input logic [5:0] zmd,
	input logic frame_start,
	output video_pkg::color_idx_t border,
	output logic gfx_en,
	output video_pkg::page_t vpage,
	input video_pkg::color_idx_t pal_idx,
	output video_pkg::color_t pal_color
);

	video_pkg::color_idx_t border_sh;
	video_pkg::color_idx_t border_q;
	logic gfx_sh;
	logic gfx_q;
	video_pkg::page_t vpage_sh;
	video_pkg::color_t cram [0:15];

	// cpu writes land in the shadows first
	always_ff @(posedge clk) begin
		if (rst) begin
			border_sh <= '0;
			gfx_sh <= 1'b0;
			vpage_sh <= '0;
		end else begin
			if (border_wr)
				border_sh <= d[3:0];
			if (vconf_wr)
				gfx_sh <= d[0];
			if (vpage_wr)
				vpage_sh <= d;
		end
	end

	// live values switch over at the top of the frame
	always_ff @(posedge clk) begin
		if (rst) begin
			border_q <= '0;
			gfx_q <= 1'b0;
		end else if (frame_start) begin
			border_q <= border_sh;
			gfx_q <= gfx_sh;
		end
	end

	// bypass so pixel (0,0) already sees the new frame values
	assign border = frame_start ? border_sh : border_q;
	assign gfx_en = frame_start ? gfx_sh : gfx_q;

	// the fetcher takes the page one line ahead of the frame it is used in
	assign vpage = vpage_sh;

	// colour ram, cpu writes apply at once
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 16; i++)
				cram[i] <= '0;
		end else if (cram_we) begin
			cram[zma] <= zmd;
		end
	end

	// registered read for the renderer
	always_ff @(posedge clk) begin
		pal_color <= cram[pal_idx];
	end

endmodule

//--- video_pkg.sv
package video_pkg;

	// dram word address {page[7:0], row[6:0], word[5:0]}
	typedef logic [20:0] dram_addr_t;

	// four pixels per word, high nibble first
	typedef logic [15:0] dram_word_t;

	// palette index
	typedef logic [3:0] color_idx_t;

	// {red[1:0], green[1:0], blue[1:0]}
	typedef logic [5:0] color_t;

	// video page, top bits of the dram address
	typedef logic [7:0] page_t;

	// hsync starts this many cycles after the active window ends
	localparam int H_SYNC_START_OFS = 4;
	localparam int H_SYNC_LEN = 8;

	// vsync in lines, counted from the end of the active rows
	localparam int V_SYNC_START_OFS = 1;
	localparam int V_SYNC_LEN = 1;

	// line fetcher states
	typedef enum logic [1:0] {
		IDLE,
		REQUEST,
		DONE
	} fetch_state_t;

endpackage
